//--- hw/alu_config.svh
// Execute cluster configuration
// Datapath width, lane count and optional Zbb logic ops
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// Datapath
`define XLEN      32   // One machine word
`define LOG_XLEN  5    // Shift amount width

// Bundle shape, 1 to 8 lanes
`define NUM_LANES 4

// Zbb andn/orn/xnor decode, 0 makes them illegal
`define ZBB_SUPPORTED 1

`endif

//--- hw/aluPkg.sv
// Execute cluster types
// Opcodes, result select coding and the packed bundle structs
`include "alu_config.svh"

package aluPkg;

  // Major opcodes handled by the cluster
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011
  } opcodeT;

  // Result mux select, follows funct3 except for right shifts
  typedef enum logic [2:0] {
    SEL_SUM   = 3'b000,  // add, sub
    SEL_SHIFT = 3'b001,  // sll, srl, sra
    SEL_SLT   = 3'b010,
    SEL_SLTU  = 3'b011,
    SEL_XOR   = 3'b100,  // xor, xnor
    SEL_RSVD  = 3'b101,  // Illegal ops land here
    SEL_OR    = 3'b110,  // or, orn
    SEL_AND   = 3'b111   // and, andn
  } aluSelT;

  ////////////////////////////////////////////////////////////////////
  // Issue side
  ////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic              valid;
    logic [6:0]        opcode;   // Raw, may hold any encoding
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic [4:0]        rd;
    logic [`XLEN-1:0]  rs1Val;
    logic [`XLEN-1:0]  rs2Val;
    logic [11:0]       imm;
  } issueSlotT;

  typedef issueSlotT [`NUM_LANES-1:0] issueBundleT;

  ////////////////////////////////////////////////////////////////////
  // Lane and writeback side
  ////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic              valid;
    logic              illegal;
    logic [4:0]        rd;
    logic [`XLEN-1:0]  a;
    logic [`XLEN-1:0]  b;
    aluSelT            aluSel;
    logic              subArith;    // Subtract or arithmetic shift
    logic              invB;        // Zbb negate of b
    logic              shiftRight;
  } laneOpT;

  typedef struct packed {
    logic              valid;
    logic              illegal;
    logic [4:0]        rd;
    logic [`XLEN-1:0]  value;
  } laneResT;

  // Valid here means the register write is performed
  typedef laneResT [`NUM_LANES-1:0] wbBundleT;

endpackage

//--- hw/aluDispatch.sv
// Bundle dispatcher
// Decodes each issue slot into a lane op and registers it
`timescale 1ns/1ps
`include "alu_config.svh"

module aluDispatch import aluPkg::*; (
  input  logic                     clk,
  input  logic                     rstN,
  input  issueBundleT              issue,     // One bundle per cycle
  output laneOpT [`NUM_LANES-1:0]  laneOps    // Registered, one per lane
);

  laneOpT [`NUM_LANES-1:0] nextOps;

  // Per-slot decode, pure function of the slot
  function automatic laneOpT decodeSlot(issueSlotT s);
    laneOpT     o;
    logic [6:0] f7;
    logic       isOp, isImm, isShift, alt, zbbOp, legal;
    isOp    = (s.opcode == OP);
    isImm   = (s.opcode == OP_IMM);
    isShift = (s.funct3[1:0] == 2'b01);                        // sll, srl/sra
    // Immediate shifts carry funct7 in imm[11:5], other immediates have none
    f7      = isOp ? s.funct7 : (isShift ? s.imm[11:5] : 7'b0);
    alt     = (f7 == 7'b0100000);
    zbbOp   = (`ZBB_SUPPORTED != 0) && isOp && (s.funct3 inside {3'b100, 3'b110, 3'b111});
    legal   = (isOp || isImm) &&
              ((f7 == 7'b0) ||
               (alt && ((s.funct3 == 3'b101) || (isOp && s.funct3 == 3'b000) || zbbOp)));

    o.valid      = s.valid;
    o.illegal    = ~legal;
    o.rd         = s.rd;
    o.a          = s.rs1Val;
    o.b          = isImm ? {{(`XLEN-12){s.imm[11]}}, s.imm} : s.rs2Val;  // Sign-extend imm
    // Compares subtract too, LT/LTU come from the difference
    o.subArith   = legal && ((s.funct3[2:1] == 2'b01) ||
                             (alt && (s.funct3 == 3'b000 || s.funct3 == 3'b101)));
    o.invB       = legal && alt && zbbOp;
    o.shiftRight = s.funct3[2];
    if (!legal) begin
      o.aluSel = SEL_RSVD;
    end else if (s.funct3 == 3'b101) begin
      o.aluSel = SEL_SHIFT;                                     // srl/sra share the shifter
    end else begin
      o.aluSel = aluSelT'(s.funct3);
    end
    return o;
  endfunction

  always_comb begin
    for (int i = 0; i < `NUM_LANES; i++) begin
      nextOps[i] = decodeSlot(issue[i]);
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Decode register, only the strobes see reset
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    laneOps <= nextOps;
    if (!rstN) begin
      for (int i = 0; i < `NUM_LANES; i++) begin
        laneOps[i].valid   <= 1'b0;
        laneOps[i].illegal <= 1'b0;
      end
    end
  end

  // Foreign opcodes and stray OP funct7 values come out illegal on the reserved select
  for (genvar i = 0; i < `NUM_LANES; i++) begin : genSelCheck
    assert property (@(posedge clk) disable iff (!rstN)
      (!(issue[i].opcode inside {OP, OP_IMM}) ||
       (issue[i].opcode == OP && !(issue[i].funct7 inside {7'b0000000, 7'b0100000})))
      |=> laneOps[i].illegal && (laneOps[i].aluSel == SEL_RSVD));
  end

endmodule

//--- hw/shifter.sv
// Barrel shifter
// One sign-filled right shifter, bit reversal around it for left shifts
`timescale 1ns/1ps
`include "alu_config.svh"

module shifter (
  input  logic [`XLEN-1:0]      a,
  input  logic [`LOG_XLEN-1:0]  amt,
  input  logic                  right,   // 0 shifts left
  input  logic                  sign,    // Fill bit for arithmetic right
  output logic [`XLEN-1:0]      y
);

  logic [`XLEN-1:0] revA, shIn, shOut, revOut;
  logic [`XLEN:0]   extIn, extOut;       // One extra bit carries the fill

  // Reverse both ways, left shift is a reversed right shift
  always_comb begin
    for (int i = 0; i < `XLEN; i++) begin
      revA[i]   = a[`XLEN-1-i];
      revOut[i] = shOut[`XLEN-1-i];
    end
  end

  assign shIn   = right ? a : revA;
  assign extIn  = {sign & right, shIn};            // Left shifts always fill zeros
  assign extOut = $signed(extIn) >>> amt;
  assign shOut  = extOut[`XLEN-1:0];

  assign y = right ? shOut : revOut;

endmodule

//--- hw/alu.sv
// Integer ALU for one lane
// Adder, compare flags, shifter and logic ops behind one result mux
`timescale 1ns/1ps
`include "alu_config.svh"

module alu import aluPkg::*; (
  input  laneOpT            op,       // Decoded lane op
  output logic [`XLEN-1:0]  result
);

  logic [`XLEN-1:0] condInvB;     // b, or ~b on subtract and Zbb negate
  logic [`XLEN-1:0] sum;
  logic [`XLEN-1:0] shift;
  logic             carry;        // Adder carry out
  logic             neg;          // Sign of the difference
  logic             aSign, bSign;
  logic             lt, ltu;

  ////////////////////////////////////////////////////////////////////
  // Adder
  ////////////////////////////////////////////////////////////////////

  assign condInvB     = (op.subArith | op.invB) ? ~op.b : op.b;
  assign {carry, sum} = op.a + condInvB + {{(`XLEN-1){1'b0}}, op.subArith};  // +1 completes -b

  // Shift amount is the low bits of b, imm or rs2
  shifter uShifter (
    .a     (op.a),
    .amt   (op.b[`LOG_XLEN-1:0]),
    .right (op.shiftRight),
    .sign  (op.subArith & op.a[`XLEN-1]),  // sra fills with the sign of a
    .y     (shift)
  );

  ////////////////////////////////////////////////////////////////////
  // Compare flags from a - b
  ////////////////////////////////////////////////////////////////////

  assign neg   = sum[`XLEN-1];
  assign aSign = op.a[`XLEN-1];
  assign bSign = op.b[`XLEN-1];
  // Signed less-than without a separate overflow term
  assign lt    = aSign & ~bSign | aSign & neg | ~bSign & neg;
  assign ltu   = ~carry;                    // Borrow out

  // Result select
  always_comb begin
    case (op.aluSel)
      SEL_SUM:   result = sum;                              // add, sub
      SEL_SHIFT: result = shift;                            // sll, srl, sra
      SEL_SLT:   result = {{(`XLEN-1){1'b0}}, lt};
      SEL_SLTU:  result = {{(`XLEN-1){1'b0}}, ltu};
      SEL_XOR:   result = op.a ^ condInvB;                  // xor, xnor
      SEL_OR:    result = op.a | condInvB;                  // or, orn
      SEL_AND:   result = op.a & condInvB;                  // and, andn
      default:   result = '0;                               // Reserved, illegal op
    endcase
  end

endmodule

//--- hw/aluLane.sv
// ALU lane
// Computes one op and registers the result for the collector
`timescale 1ns/1ps
`include "alu_config.svh"

module aluLane import aluPkg::*; (
  input  logic     clk,
  input  logic     rstN,
  input  laneOpT   op,      // From the dispatcher register
  output laneResT  res      // One cycle after op
);

  logic [`XLEN-1:0] value;

  alu uAlu (
    .op     (op),
    .result (value)
  );

  // Result stage, lets the next bundle enter behind this one
  always_ff @(posedge clk) begin
    res.value <= value;
    res.rd    <= op.rd;
    if (!rstN) begin
      res.valid   <= 1'b0;
      res.illegal <= 1'b0;
    end else begin
      res.valid   <= op.valid;
      res.illegal <= op.valid & op.illegal;   // Only meaningful with valid
    end
  end

  // Illegal ops reach the ALU on the reserved select and leave a zero value
  assert property (@(posedge clk) disable iff (!rstN)
    res.illegal |-> (res.value == '0));

endmodule

//--- hw/resultCollect.sv
// Writeback collector
// Drops x0 writes, keeps the youngest write per rd, flags illegal lanes
`timescale 1ns/1ps
`include "alu_config.svh"

module resultCollect import aluPkg::*; (
  input  logic                      clk,
  input  logic                      rstN,
  input  laneResT [`NUM_LANES-1:0]  laneRes,
  output wbBundleT                  wb,
  output logic [`NUM_LANES-1:0]     illegalStrobe
);

  wbBundleT               nextWb;
  logic [`NUM_LANES-1:0]  keep;          // Lane write survives the filters
  logic [`NUM_LANES-1:0]  nextStrobe;
  logic                   dupRd;         // Two valid wb slots share an rd

  // Higher lane is younger and wins on the same rd
  always_comb begin
    for (int i = 0; i < `NUM_LANES; i++) begin
      keep[i] = laneRes[i].valid & ~laneRes[i].illegal & (laneRes[i].rd != 5'd0);
      for (int j = i + 1; j < `NUM_LANES; j++) begin
        if (laneRes[j].valid && !laneRes[j].illegal && laneRes[j].rd == laneRes[i].rd)
          keep[i] = 1'b0;
      end
      nextStrobe[i]     = laneRes[i].valid & laneRes[i].illegal;
      nextWb[i]         = laneRes[i];   // value, rd pass through
      nextWb[i].valid   = keep[i];
      nextWb[i].illegal = nextStrobe[i];
    end
  end

  always_ff @(posedge clk) begin
    wb            <= nextWb;
    illegalStrobe <= rstN ? nextStrobe : '0;
    if (!rstN) begin
      for (int i = 0; i < `NUM_LANES; i++) begin
        wb[i].valid   <= 1'b0;
        wb[i].illegal <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Output check
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    dupRd = 1'b0;
    for (int i = 0; i < `NUM_LANES; i++)
      for (int j = i + 1; j < `NUM_LANES; j++)
        if (wb[i].valid && wb[j].valid && wb[i].rd == wb[j].rd) dupRd = 1'b1;
  end

  assert property (@(posedge clk) disable iff (!rstN) !dupRd);

endmodule

//--- hw/exeCluster.sv
// Bundle-issue execute cluster
// Dispatcher, NUM_LANES ALU lanes and the writeback collector, 3-cycle latency
`timescale 1ns/1ps
`include "alu_config.svh"

module exeCluster import aluPkg::*; (
  input  logic                   clk,
  input  logic                   rstN,
  input  issueBundleT            issue,          // Sampled every edge
  output wbBundleT               wb,             // Issue + 3 cycles
  output logic [`NUM_LANES-1:0]  illegalStrobe
);

  laneOpT  [`NUM_LANES-1:0] laneOps;    // Stage 1, decoded
  laneResT [`NUM_LANES-1:0] laneRes;    // Stage 2, computed

  aluDispatch uDispatch (
    .clk     (clk),
    .rstN    (rstN),
    .issue   (issue),
    .laneOps (laneOps)
  );

  // Identical lanes, one per issue slot
  for (genvar i = 0; i < `NUM_LANES; i++) begin : genLane
    aluLane uLane (
      .clk  (clk),
      .rstN (rstN),
      .op   (laneOps[i]),
      .res  (laneRes[i])
    );
  end

  // Stage 3, merged writeback
  resultCollect uCollect (
    .clk           (clk),
    .rstN          (rstN),
    .laneRes       (laneRes),
    .wb            (wb),
    .illegalStrobe (illegalStrobe)
  );

endmodule

//--- sim/exeClusterTb.sv
// Execute cluster testbench
// Random bundles against an ISA model, writeback compared 3 cycles after issue
`timescale 1ns/1ps
`include "alu_config.svh"

module exeClusterTb import aluPkg::*; ();

  localparam int N           = `NUM_LANES;
  localparam int NUM_BUNDLES = 2000;
  localparam int LATENCY     = 3;                                  // Issue to wb, in cycles
  localparam int TIMEOUT_NS  = (NUM_BUNDLES + LATENCY + 4) * 4 + 200;  // Reset plus margin

  logic          clk;
  logic          rstN;
  issueBundleT   issue;
  wbBundleT      wb;
  logic [N-1:0]  illegalStrobe;

  wbBundleT      expWbQ[$];       // One entry per issued cycle
  logic [N-1:0]  expStrobeQ[$];
  logic [N-1:0]  liveQ[$];        // Lanes whose rd and value get compared
  int            wbErrors;
  int            strobeErrors;

  exeCluster UUT (
    .clk           (clk),
    .rstN          (rstN),
    .issue         (issue),
    .wb            (wb),
    .illegalStrobe (illegalStrobe)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;                                        // 4 ns period
  end

  ////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////

  // Sign boundaries and all-ones show up often
  function automatic logic [`XLEN-1:0] edgeValue();
    case ($urandom % 6)
      0:       return 32'h8000_0000;
      1:       return 32'h7fff_ffff;
      2:       return '1;
      3:       return '0;
      default: return $urandom;
    endcase
  endfunction

  function automatic logic [4:0] edgeShamt();
    case ($urandom % 3)
      0:       return 5'd0;
      1:       return 5'd31;
      default: return 5'($urandom);
    endcase
  endfunction

  // Mostly legal OP/OP_IMM encodings, small rd so lanes collide
  function automatic issueSlotT randomSlot();
    issueSlotT s;
    int        pick;
    s.valid  = ($urandom % 8) != 0;
    pick     = $urandom % 10;
    s.opcode = (pick < 5) ? 7'b0110011 : ((pick < 9) ? 7'b0010011 : 7'($urandom));
    s.funct3 = 3'($urandom);
    pick     = $urandom % 10;
    s.funct7 = (pick < 7) ? 7'd0 : ((pick < 9) ? 7'b0100000 : 7'($urandom));
    s.rd     = 5'($urandom % 6);
    s.rs1Val = edgeValue();
    s.rs2Val = edgeValue();
    s.imm    = 12'($urandom);
    if (s.funct3[1:0] == 2'b01) s.imm = {s.funct7, edgeShamt()};  // Shift imm layout
    return s;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////

  function automatic laneResT modelSlot(issueSlotT s);
    laneResT          r;
    logic [`XLEN-1:0] a, b, sra;
    logic [6:0]       f7;
    logic             isOp, isImm, alt, legal;
    isOp  = (s.opcode == 7'b0110011);
    isImm = (s.opcode == 7'b0010011);
    a     = s.rs1Val;
    b     = isOp ? s.rs2Val : {{(`XLEN-12){s.imm[11]}}, s.imm};
    f7    = isOp ? s.funct7 : ((s.funct3[1:0] == 2'b01) ? s.imm[11:5] : 7'd0);
    alt   = (f7 == 7'b0100000);
    sra   = $signed(a) >>> b[4:0];
    case (s.funct3)
      3'b000:                 legal = !alt || isOp;                 // sub has no imm form
      3'b101:                 legal = 1'b1;                         // srl, sra
      3'b100, 3'b110, 3'b111: legal = !alt || (isOp && `ZBB_SUPPORTED != 0);
      default:                legal = !alt;
    endcase
    legal = legal && (isOp || isImm) && (f7 == 7'd0 || alt);
    case (s.funct3)
      3'b000:  r.value = alt ? a - b : a + b;
      3'b001:  r.value = a << b[4:0];
      3'b010:  r.value = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      3'b011:  r.value = {{(`XLEN-1){1'b0}}, a < b};
      3'b100:  r.value = alt ? ~(a ^ b) : a ^ b;                    // xnor
      3'b101:  r.value = alt ? sra : a >> b[4:0];
      3'b110:  r.value = alt ? a | ~b : a | b;                      // orn
      default: r.value = alt ? a & ~b : a & b;                      // andn
    endcase
    r.valid   = s.valid;
    r.illegal = !legal;
    r.rd      = s.rd;
    return r;
  endfunction

  // x0 filter, younger lane wins on a shared rd
  task automatic expectBundle(input issueBundleT bun, output wbBundleT exp,
                              output logic [N-1:0] strobe, output logic [N-1:0] live);
    laneResT      r [N];
    logic [N-1:0] ok;
    for (int i = 0; i < N; i++) begin
      r[i]  = modelSlot(bun[i]);
      ok[i] = r[i].valid && !r[i].illegal;
    end
    for (int i = 0; i < N; i++) begin
      exp[i]       = r[i];
      exp[i].valid = ok[i] && (r[i].rd != 5'd0);
      for (int j = i + 1; j < N; j++)
        if (ok[j] && r[j].rd == r[i].rd) exp[i].valid = 1'b0;
      exp[i].illegal = r[i].valid && r[i].illegal;
      strobe[i]      = exp[i].illegal;
      live[i]        = ok[i];
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////

  task automatic checkWb(input wbBundleT got, input wbBundleT exp, input logic [N-1:0] live);
    for (int i = 0; i < N; i++) begin
      if (got[i].valid !== exp[i].valid) begin
        wbErrors++;
        $display("[ERROR] %0t: wb lane %0d valid %b, expected %b",
                 $time, i, got[i].valid, exp[i].valid);
      end else if (got[i].illegal !== exp[i].illegal) begin
        wbErrors++;
        $display("[ERROR] %0t: wb lane %0d illegal %b, expected %b",
                 $time, i, got[i].illegal, exp[i].illegal);
      end else if (live[i] && (got[i].rd !== exp[i].rd || got[i].value !== exp[i].value)) begin
        wbErrors++;
        $display("[ERROR] %0t: wb lane %0d x%0d=%h, expected x%0d=%h",
                 $time, i, got[i].rd, got[i].value, exp[i].rd, exp[i].value);
      end
    end
  endtask

  task automatic checkIllegal(input logic [N-1:0] got, input logic [N-1:0] exp);
    if (got !== exp) begin
      strobeErrors++;
      $display("[ERROR] %0t: illegalStrobe %b, expected %b", $time, got, exp);
    end
  endtask

  // Main sequence, compare then drive, 1 ns after each edge
  initial begin
    issueBundleT  bun;
    wbBundleT     exp;
    logic [N-1:0] strobe, live;
    void'($urandom(32'h8bb3_6659));
    wbErrors     = 0;
    strobeErrors = 0;
    rstN         = 1'b0;
    issue        = '0;
    for (int k = 0; k < LATENCY; k++) begin                     // Idle cycles before first bundle
      expWbQ.push_back('0);
      expStrobeQ.push_back('0);
      liveQ.push_back('0);
    end
    repeat (4) @(posedge clk);
    #1 rstN = 1'b1;
    for (int k = 0; k < NUM_BUNDLES + LATENCY; k++) begin
      checkWb(wb, expWbQ.pop_front(), liveQ.pop_front());
      checkIllegal(illegalStrobe, expStrobeQ.pop_front());
      bun = '0;                                                   // Drain with empty bundles
      if (k < NUM_BUNDLES)
        for (int i = 0; i < N; i++) bun[i] = randomSlot();
      expectBundle(bun, exp, strobe, live);
      expWbQ.push_back(exp);
      expStrobeQ.push_back(strobe);
      liveQ.push_back(live);
      issue = bun;
      @(posedge clk);
      #1;
    end
    $display("Errors: wb %0d, illegal strobe %0d", wbErrors, strobeErrors);
    if (wbErrors == 0 && strobeErrors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("The run timed out before all bundles were checked");
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- exeCluster.f
+incdir+hw
hw/aluPkg.sv
hw/aluDispatch.sv
hw/shifter.sv
hw/alu.sv
hw/aluLane.sv
hw/resultCollect.sv
hw/exeCluster.sv
sim/exeClusterTb.sv

//--- run.sh
#!/bin/sh
# Build the execute cluster testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f exeCluster.f \
  --top-module exeClusterTb -o exeClusterSim \
  && ./obj_dir/exeClusterSim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
